// File: link_pkg.sv
// link channel package
// default channel sizing and the idle pattern driven on the data pins
`default_nettype none

package link_pkg;

  // default data width of the channel
  localparam int link_channel_width_c = 16;

  // log2 of the credit window, each token pool holds half of it
  localparam int link_lg_fifo_depth_c = 6;

  // log2 of the credits carried by one token edge
  localparam int link_lg_decimation_c = 3;

  // widest channel the idle pattern helper can describe
  localparam int link_max_width_c = 256;

  // idle pattern (10)+ keeps the pad current balanced while not sending
  // odd bits set, even bits clear, bits above width stay zero
  function automatic logic [link_max_width_c-1:0] link_inactive_pattern(input int width);
    logic [link_max_width_c-1:0] pattern;
    pattern = '0;
    for (int i = 0; i < link_max_width_c; i++)
    begin
      if (i < width)
        pattern[i] = (i % 2 == 1);
    end
    return pattern;
  endfunction

endpackage

`default_nettype wire

// File: link_token_pkg.sv
// token and credit types
// carried between token capture, the two credit pools and launch
`default_nettype none

package link_token_pkg;

  // one cycle pulses, one per detected token edge
  typedef struct packed {
    logic rise;
    logic fall;
  } link_token_edge_s;

  // per pool flag, set while the pool holds at least one credit
  typedef struct packed {
    logic pos;
    logic neg;
  } link_credit_avail_s;

  // per pool decrement
  // at most one field high in any cycle
  typedef struct packed {
    logic pos;
    logic neg;
  } link_credit_take_s;

endpackage

`default_nettype wire

// File: link_two_fifo.sv
// two-entry decoupling buffer on the core side of the link
// ready comes from registered state only, so io_ready_i never reaches the core
`timescale 1ns/100ps
`default_nettype none

module link_two_fifo
  #(parameter int channel_width_p = 16)
  ( input  wire                        io_clk_i
  , input  wire                        io_link_reset_i

  , input  wire  [channel_width_p-1:0] data_i
  , input  wire                        valid_i
  , output logic                       ready_o

  , output logic                       valid_o
  , output logic [channel_width_p-1:0] data_o
  , input  wire                        yumi_i
  );

  // payload storage
  logic [channel_width_p-1:0] mem_r [2];

  logic wptr_r, rptr_r;
  logic empty_r;
  // registered not-full, also held low through reset
  logic ready_r;

  logic enq, deq;
  logic empty_n, full_n;
  logic full;

  assign enq = valid_i & ready_r;
  assign deq = yumi_i;

  // equal pointers with the empty bit clear means both slots hold words
  assign full = (wptr_r == rptr_r) & ~empty_r;

  always_comb
  begin
    empty_n = empty_r;
    full_n  = full;
    // enq cannot hit a full buffer and deq cannot hit an empty one
    if (enq & ~deq)
    begin
      empty_n = 1'b0;
      // second word arriving
      full_n  = (wptr_r != rptr_r);
    end
    else if (deq & ~enq)
    begin
      // last word leaving
      empty_n = (wptr_r != rptr_r);
      full_n  = 1'b0;
    end
  end

  always_ff @(posedge io_clk_i)
  begin
    if (io_link_reset_i)
    begin
      wptr_r  <= 1'b0;
      rptr_r  <= 1'b0;
      empty_r <= 1'b1;
      ready_r <= 1'b0;
    end
    else
    begin
      wptr_r  <= wptr_r ^ enq;
      rptr_r  <= rptr_r ^ deq;
      empty_r <= empty_n;
      ready_r <= ~full_n;
    end
  end

  // storage write
  always_ff @(posedge io_clk_i)
  begin
    if (enq)
      mem_r[wptr_r] <= data_i;
  end

  assign ready_o = ready_r;
  assign valid_o = ~empty_r;
  assign data_o  = mem_r[rptr_r];

  // the consumer may only take a word the buffer offers
  a_yumi_needs_valid: assert property (
    @(posedge io_clk_i) disable iff (io_link_reset_i) yumi_i |-> valid_o);

endmodule

`default_nettype wire

// File: link_token_sync.sv
// token capture
// samples the token wire in the io clock domain and emits one pulse per edge
`timescale 1ns/100ps
`default_nettype none

module link_token_sync
  import link_token_pkg::*;
  ( input  wire              io_clk_i
  , input  wire              io_link_reset_i
  , input  wire              token_clk_i
  , output link_token_edge_s token_edge_o
  );

  // two flop synchronizer plus history for edge detection
  logic sync1_r, sync2_r, hist_r;
  // low through reset so no edge is reported for the value left on the wire
  logic armed_r;

  // synchronizer and history chain, sampled on every io clock
  always_ff @(posedge io_clk_i)
  begin
    sync1_r <= token_clk_i;
    sync2_r <= sync1_r;
    hist_r  <= sync2_r;
  end

  always_ff @(posedge io_clk_i)
  begin
    if (io_link_reset_i)
      armed_r <= 1'b0;
    else
      armed_r <= 1'b1;
  end

  // ********************************************************************
  // edge pulses
  // ********************************************************************

  // 0 -> 1 on the synchronized wire
  assign token_edge_o.rise = armed_r & sync2_r & ~hist_r;
  // 1 -> 0 on the synchronized wire
  assign token_edge_o.fall = armed_r & ~sync2_r & hist_r;

  // token wire holds each level for at least two io clocks
  a_token_slow: assert property (
    @(posedge io_clk_i) disable iff (io_link_reset_i)
      (token_edge_o.rise || token_edge_o.fall)
        |=> !(token_edge_o.rise || token_edge_o.fall));

endmodule

`default_nettype wire

// File: link_credit_counter.sv
// saturating credit pool for one token edge
// refilled by token pulses, drained one credit per send
`timescale 1ns/100ps
`default_nettype none

module link_credit_counter
  #( parameter int lg_fifo_depth_p                 = 6
   , parameter int lg_credit_to_token_decimation_p = 3
   )
  ( input  wire  io_clk_i
  , input  wire  io_link_reset_i
  , input  wire  add_i
  , input  wire  take_i
  , output logic avail_o
  );

  // ********************************************************************
  // sizing
  // ********************************************************************

  // one pool covers half the credit window
  localparam logic [lg_fifo_depth_p:0] full_lp =
    (lg_fifo_depth_p+1)'(2 ** (lg_fifo_depth_p - 1));

  // credits carried by a single token edge
  localparam logic [lg_fifo_depth_p:0] refill_lp =
    (lg_fifo_depth_p+1)'(2 ** lg_credit_to_token_decimation_p);

  // count range is 0 .. full_lp
  logic [lg_fifo_depth_p-1:0] count_r;

  // one extra bit so the refill sum cannot wrap
  logic [lg_fifo_depth_p:0] sum;
  logic [lg_fifo_depth_p:0] sat;
  logic [lg_fifo_depth_p:0] count_n;

  // ********************************************************************
  // next count
  // ********************************************************************

  always_comb
  begin
    // refill first
    sum = {1'b0, count_r};
    if (add_i)
      sum = sum + refill_lp;

    // tokens beyond the window are dropped
    if (sum > full_lp)
      sat = full_lp;
    else
      sat = sum;

    // then the send of this cycle
    count_n = sat - (lg_fifo_depth_p+1)'(take_i);
  end

  always_ff @(posedge io_clk_i)
  begin
    if (io_link_reset_i)
      // receiver buffer starts empty, so every credit is ours
      count_r <= full_lp[lg_fifo_depth_p-1:0];
    else
      count_r <= count_n[lg_fifo_depth_p-1:0];
  end

  assign avail_o = (count_r != '0);

  // launch only draws from this pool while it reported credit
  a_no_take_when_empty: assert property (
    @(posedge io_clk_i) disable iff (io_link_reset_i)
      take_i |-> (count_r != '0));

endmodule

`default_nettype wire

// File: link_upstream_launch.sv
// launch stage
// picks the active credit pool, gates valid with its credit and drives
// the data pins with the word or the idle pattern
`timescale 1ns/100ps
`default_nettype none

module link_upstream_launch
  import link_pkg::*;
  import link_token_pkg::*;
  #( parameter int channel_width_p                 = 16
   , parameter int lg_credit_to_token_decimation_p = 3
   )
  ( input  wire                        io_clk_i
  , input  wire                        io_link_reset_i

  // buffer side
  , input  wire                        buf_valid_i
  , input  wire  [channel_width_p-1:0] buf_data_i
  , output logic                       buf_yumi_o

  // credit pools
  , input  link_credit_avail_s         credit_avail_i
  , output link_credit_take_s          credit_take_o

  // output PHY side
  , output logic [channel_width_p-1:0] io_data_o
  , output logic                       io_valid_o
  , input  wire                        io_ready_i
  );

  // full width helper result, sliced to the channel below
  localparam logic [link_max_width_c-1:0] pattern_full_lp =
    link_inactive_pattern(channel_width_p);

  localparam logic [channel_width_p-1:0] inactive_pattern_lp =
    pattern_full_lp[channel_width_p-1:0];

  // ********************************************************************
  // token alternator
  // ********************************************************************

  // counts sends, wraps freely
  // high bit clear selects the rising edge pool, set selects falling
  logic [lg_credit_to_token_decimation_p:0] alt_r;
  logic on_neg;
  logic credit_ok;
  logic valid_n;
  logic send;

  assign on_neg = alt_r[lg_credit_to_token_decimation_p];

  // credit of the pool currently being drawn from
  assign credit_ok = on_neg ? credit_avail_i.neg : credit_avail_i.pos;

  // a word goes out only with data and credit both present
  assign valid_n = buf_valid_i & credit_ok;
  assign send    = valid_n & io_ready_i;

  always_ff @(posedge io_clk_i)
  begin
    if (io_link_reset_i)
      // start on the rising edge pool
      alt_r <= '0;
    else if (send)
      alt_r <= alt_r + 1'b1;
  end

  // ********************************************************************
  // handshakes and pins
  // ********************************************************************

  assign buf_yumi_o = send;

  // only the active pool is charged
  assign credit_take_o.pos = send & ~on_neg;
  assign credit_take_o.neg = send & on_neg;

  assign io_valid_o = valid_n;

  // real word shown whenever valid, even with the PHY stalled, to save toggles
  // reset empties the buffer, so the idle pattern also covers reset
  always_comb
  begin
    if (valid_n)
      io_data_o = buf_data_i;
    else
      io_data_o = inactive_pattern_lp;
  end

  // a stalled word stays on the pins until the PHY takes it
  a_stall_holds_word: assert property (
    @(posedge io_clk_i) disable iff (io_link_reset_i)
      (io_valid_o && !io_ready_i) |=> (io_valid_o && $stable(io_data_o)));

endmodule

`default_nettype wire

// File: link_upstream.sv
// transmit half of the source-synchronous link
// core words pass a two-entry buffer and leave only against token credits
// counted separately for rising and falling token edges
`timescale 1ns/100ps
`default_nettype none

module link_upstream
  import link_pkg::*;
  import link_token_pkg::*;
  #( parameter int channel_width_p                 = link_channel_width_c
   , parameter int lg_fifo_depth_p                 = link_lg_fifo_depth_c
   , parameter int lg_credit_to_token_decimation_p = link_lg_decimation_c
   )
  ( input  wire                        io_clk_i
  , input  wire                        io_link_reset_i

  // from the chip core
  , input  wire  [channel_width_p-1:0] core_data_i
  , input  wire                        core_valid_i
  , output logic                       core_ready_o

  // to the output PHY
  , output logic [channel_width_p-1:0] io_data_o
  , output logic                       io_valid_o
  , input  wire                        io_ready_i

  // returned tokens, sampled as a slow toggling wire
  , input  wire                        token_clk_i
  );

  logic                       buf_valid;
  logic [channel_width_p-1:0] buf_data;
  logic                       buf_yumi;

  link_token_edge_s   token_edge;
  link_credit_avail_s credit_avail;
  link_credit_take_s  credit_take;

  // ********************************************************************
  // core side buffer
  // ********************************************************************

  link_two_fifo #(.channel_width_p(channel_width_p)) i_two_fifo
    ( .io_clk_i       (io_clk_i)
    , .io_link_reset_i(io_link_reset_i)
    , .data_i         (core_data_i)
    , .valid_i        (core_valid_i)
    , .ready_o        (core_ready_o)
    , .valid_o        (buf_valid)
    , .data_o         (buf_data)
    , .yumi_i         (buf_yumi)
    );

  // ********************************************************************
  // token capture and credit pools
  // ********************************************************************

  link_token_sync i_token_sync
    ( .io_clk_i       (io_clk_i)
    , .io_link_reset_i(io_link_reset_i)
    , .token_clk_i    (token_clk_i)
    , .token_edge_o   (token_edge)
    );

  // rising edge credits
  link_credit_counter
    #( .lg_fifo_depth_p                (lg_fifo_depth_p)
     , .lg_credit_to_token_decimation_p(lg_credit_to_token_decimation_p)
     ) i_pos_credit
    ( .io_clk_i       (io_clk_i)
    , .io_link_reset_i(io_link_reset_i)
    , .add_i          (token_edge.rise)
    , .take_i         (credit_take.pos)
    , .avail_o        (credit_avail.pos)
    );

  // falling edge credits
  link_credit_counter
    #( .lg_fifo_depth_p                (lg_fifo_depth_p)
     , .lg_credit_to_token_decimation_p(lg_credit_to_token_decimation_p)
     ) i_neg_credit
    ( .io_clk_i       (io_clk_i)
    , .io_link_reset_i(io_link_reset_i)
    , .add_i          (token_edge.fall)
    , .take_i         (credit_take.neg)
    , .avail_o        (credit_avail.neg)
    );

  // ********************************************************************
  // launch
  // ********************************************************************

  link_upstream_launch
    #( .channel_width_p                (channel_width_p)
     , .lg_credit_to_token_decimation_p(lg_credit_to_token_decimation_p)
     ) i_launch
    ( .io_clk_i       (io_clk_i)
    , .io_link_reset_i(io_link_reset_i)
    , .buf_valid_i    (buf_valid)
    , .buf_data_i     (buf_data)
    , .buf_yumi_o     (buf_yumi)
    , .credit_avail_i (credit_avail)
    , .credit_take_o  (credit_take)
    , .io_data_o      (io_data_o)
    , .io_valid_o     (io_valid_o)
    , .io_ready_i     (io_ready_i)
    );

endmodule

`default_nettype wire

// File: tb_link_upstream.sv
// testbench for the link transmit half
// table-driven rows of core words and token periods, LFSR data and back-pressure,
// scoreboard and credit reference model checked at every cycle
`timescale 1ns/100ps
`default_nettype none

module tb_link_upstream
  import link_pkg::*;
  ;

  localparam int channel_width_lp = link_channel_width_c;
  localparam int lg_fifo_depth_lp = link_lg_fifo_depth_c;
  localparam int lg_decim_lp      = link_lg_decimation_c;
  // credits per pool after reset, and per token edge
  localparam int pool_full_lp     = 2 ** (lg_fifo_depth_lp - 1);
  localparam int refill_lp        = 2 ** lg_decim_lp;
  localparam int quiet_cycles_lp  = 50;

  typedef struct {
    string name;
    int    words;
    int    periods;
    bit    lfsr_ready;
    int    exp_sent;
  } row_t;

  // exhaust runs on pools left full by the saturate row
  // refill leaves words queued so only the credit limit ends its sends
  row_t rows [6] = '{
    '{"reset_idle", 0,  0, 1'b0, 0},
    '{"saturate",   0,  2, 1'b0, 0},
    '{"exhaust",    80, 0, 1'b0, 64},
    '{"refill",     4,  1, 1'b0, 80},
    '{"stream",     20, 4, 1'b0, 104},
    '{"lfsr_ready", 30, 2, 1'b1, 134}
  };

  logic                        io_clk_i;
  logic                        io_link_reset_i;
  logic [channel_width_lp-1:0] core_data_i;
  logic                        core_valid_i;
  logic                        core_ready_o;
  logic [channel_width_lp-1:0] io_data_o;
  logic                        io_valid_o;
  logic                        io_ready_i;
  logic                        token_clk_i;

  // scoreboard and reference model state
  logic [channel_width_lp-1:0] sb [$];
  logic [31:0] lfsr_r     = 32'h670f5840;
  string       cur_name   = "reset";
  bit          checking   = 1'b0;
  bit          ready_lfsr = 1'b0;
  bit          fresh      = 1'b0;
  int          pending    = 0;
  int          sent_count = 0;
  int          pos_cr     = pool_full_lp;
  int          neg_cr     = pool_full_lp;
  int          model_alt  = 0;

  link_upstream
    #( .channel_width_p                (channel_width_lp)
     , .lg_fifo_depth_p                (lg_fifo_depth_lp)
     , .lg_credit_to_token_decimation_p(lg_decim_lp)
     ) i_dut
    ( .io_clk_i       (io_clk_i)
    , .io_link_reset_i(io_link_reset_i)
    , .core_data_i    (core_data_i)
    , .core_valid_i   (core_valid_i)
    , .core_ready_o   (core_ready_o)
    , .io_data_o      (io_data_o)
    , .io_valid_o     (io_valid_o)
    , .io_ready_i     (io_ready_i)
    , .token_clk_i    (token_clk_i)
    );

  initial
  begin
    io_clk_i = 1'b0;
    forever #4 io_clk_i = ~io_clk_i;
  end

  // ********************************************************************
  // helpers and compare tasks
  // ********************************************************************

  // alternating 10 pattern, odd bits set
  function automatic logic [channel_width_lp-1:0] idle_word();
    logic [channel_width_lp-1:0] w;
    for (int i = 0; i < channel_width_lp; i++)
      w[i] = (i % 2 == 1);
    return w;
  endfunction

  // fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [channel_width_lp-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_r = lfsr_next(lfsr_r);
      v = {v[channel_width_lp-2:0], lfsr_r[0]};
    end
  endtask

  // pool picked by the send count, 2^decim sends per pool in turn
  function automatic logic model_avail();
    if (((model_alt >> lg_decim_lp) & 1) == 1)
      return neg_cr > 0;
    return pos_cr > 0;
  endfunction

  function automatic int cycle_budget();
    int total;
    total = 200;
    foreach (rows[i])
      total += 40 * rows[i].words;
    return total;
  endfunction

  task automatic report_failure();
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [channel_width_lp-1:0] exp,
                            input logic [channel_width_lp-1:0] act);
    if (exp !== act)
    begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      report_failure();
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      report_failure();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act)
    begin
      $display("Fail %s: expected %0d, actual %0d", name, exp, act);
      report_failure();
    end
  endtask

  // ********************************************************************
  // driver
  // ********************************************************************

  // one cycle, inputs change 1 ns after the rising edge
  task automatic step_cycle();
    logic [channel_width_lp-1:0] word;
    logic [channel_width_lp-1:0] bits;
    @(posedge io_clk_i);
    #1;
    // new word only after the previous one transferred
    if (pending > 0)
    begin
      if (!core_valid_i || fresh)
      begin
        draw_bits(channel_width_lp, word);
        core_data_i  = word;
        core_valid_i = 1'b1;
      end
    end
    else
      core_valid_i = 1'b0;
    fresh = 1'b0;
    if (ready_lfsr)
    begin
      draw_bits(1, bits);
      io_ready_i = bits[0];
    end
    else
      io_ready_i = 1'b1;
  endtask

  // one rise and one fall, 6 cycles apart
  // model credits land at the edge, ahead of the synchronizer
  task automatic token_period();
    step_cycle();
    token_clk_i = 1'b1;
    pos_cr = (pos_cr + refill_lp > pool_full_lp) ? pool_full_lp : pos_cr + refill_lp;
    repeat (6) step_cycle();
    token_clk_i = 1'b0;
    neg_cr = (neg_cr + refill_lp > pool_full_lp) ? pool_full_lp : neg_cr + refill_lp;
    repeat (5) step_cycle();
  endtask

  // ********************************************************************
  // monitor, mid cycle where inputs and outputs are settled
  // ********************************************************************

  always @(negedge io_clk_i)
  begin
    logic [channel_width_lp-1:0] exp_word;
    if (checking)
    begin
      // scoreboard depth equals buffer occupancy here
      check_valid({cur_name, " core_ready"}, sb.size() < 2, core_ready_o);
      if (io_valid_o)
      begin
        check_valid({cur_name, " queued word"}, 1'b1, sb.size() != 0);
        check_valid({cur_name, " credit"}, 1'b1, model_avail());
        if (io_ready_i)
        begin
          exp_word = sb.pop_front();
          check_word({cur_name, " data"}, exp_word, io_data_o);
          if (((model_alt >> lg_decim_lp) & 1) == 1)
            neg_cr--;
          else
            pos_cr--;
          model_alt = (model_alt + 1) % (2 * refill_lp);
          sent_count++;
        end
      end
      else
        check_word({cur_name, " idle"}, idle_word(), io_data_o);
      // transfer at the coming edge
      if (core_valid_i && core_ready_o)
      begin
        sb.push_back(core_data_i);
        pending--;
        fresh = 1'b1;
      end
    end
  end

  initial
  begin
    int limit;
    limit = cycle_budget();
    repeat (limit) @(posedge io_clk_i);
    $display("timeout: run did not finish within %0d cycles", limit);
    report_failure();
  end

  // ********************************************************************
  // main sequence
  // ********************************************************************

  initial
  begin
    io_link_reset_i = 1'b1;
    core_data_i     = '0;
    core_valid_i    = 1'b0;
    io_ready_i      = 1'b1;
    token_clk_i     = 1'b0;

    for (int c = 0; c < 8; c++)
    begin
      step_cycle();
      // reset drops after its eighth edge
      if (c == 7)
        io_link_reset_i = 1'b0;
      #2;
      check_valid("reset valid", 1'b0, io_valid_o);
      check_valid("reset core_ready", 1'b0, core_ready_o);
      check_word("reset idle", idle_word(), io_data_o);
    end
    step_cycle();
    checking = 1'b1;
    #2;
    check_valid("after reset core_ready", 1'b1, core_ready_o);

    foreach (rows[r])
    begin
      cur_name   = rows[r].name;
      ready_lfsr = rows[r].lfsr_ready;
      repeat (rows[r].periods) token_period();
      pending += rows[r].words;
      while (sent_count < rows[r].exp_sent)
        step_cycle();
      // nothing more may leave once the row has settled
      repeat (quiet_cycles_lp)
      begin
        step_cycle();
        #2;
        check_count({cur_name, " sends"}, rows[r].exp_sent, sent_count);
        check_valid({cur_name, " settled valid"}, (sb.size() != 0) && model_avail(),
                    io_valid_o);
      end
    end

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// File: link_upstream.f
link_pkg.sv
link_token_pkg.sv
link_two_fifo.sv
link_token_sync.sv
link_credit_counter.sv
link_upstream_launch.sv
link_upstream.sv
tb_link_upstream.sv

// File: Bender.yml
package:
  name: link_upstream

sources:
  - link_pkg.sv
  - link_token_pkg.sv
  - link_two_fifo.sv
  - link_token_sync.sv
  - link_credit_counter.sv
  - link_upstream_launch.sv
  - link_upstream.sv
  - target: simulation
    files:
      - tb_link_upstream.sv
